// File: sim.f
+incdir+include
logic/gcu_pkg.sv
logic/gcu_bus_ctrl.sv
logic/vram_bank.sv
logic/cpu_read_seq.sv
logic/frame_sync_irq.sv
logic/gcu_top.sv
sim/tb_gcu.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs tb_gcu with Verilator; the result is read from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_gcu -f sim.f > build.log 2>&1 \
    && ./obj_dir/Vtb_gcu > sim.log 2>&1 \
    || echo "build or simulation exited with an error"
grep -qx '\*\* PASS \*\*' sim.log && echo "simulation passed" && exit 0
echo "simulation failed"
exit 1

// File: include/tb_gcu_checks.svh
// compare and wait tasks for tb_gcu; needs CLK96, ack, vint, the timeouts and stop_run in scope
`ifndef TB_GCU_CHECKS_SVH
`define TB_GCU_CHECKS_SVH

task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
        stop_run($sformatf("[FAIL] t=%0t %s is %h, expected %h", $time, what, got, exp));
    end
endtask

task automatic check_scroll(
    input layer_scroll_t got,
    input layer_scroll_t exp,
    input string         what
);
    if (got !== exp) begin
        stop_run($sformatf("[FAIL] t=%0t %s is %h, expected %h", $time, what, got, exp));
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        stop_run($sformatf("[FAIL] t=%0t %s is %b, expected %b", $time, what, got, exp));
    end
endtask

// levels are sampled on the falling edge
task automatic wait_ack();
    int n;
    n = 0;
    @(negedge CLK96);
    while (ack !== 1'b1) begin
        if (n >= ACK_TIMEOUT) begin
            stop_run($sformatf("ack stayed low for %0d cycles at time %0t", n, $time));
        end
        n++;
        @(negedge CLK96);
    end
endtask

task automatic wait_vint(input logic exp);
    int n;
    n = 0;
    @(negedge CLK96);
    while (vint !== exp) begin
        if (n >= VINT_TIMEOUT) begin
            stop_run($sformatf("vint did not reach %b within %0d cycles", exp, n));
        end
        n++;
        @(negedge CLK96);
    end
endtask

`endif

// File: sim/tb_gcu.sv
// fixed-seed LCG stimulus; video RAM is compared only at addresses this test has written
`timescale 1ns/1ps
`default_nettype none

module tb_gcu;
    import gcu_pkg::*;

    localparam int ACK_TIMEOUT  = 16;
    localparam int VINT_TIMEOUT = 16;
    localparam int RUN_LEN      = 6;

    localparam gcu_op_t OP_SELECT    = '{select_reg: 1'b1, default: 1'b0};
    localparam gcu_op_t OP_WRITE_REG = '{write_reg: 1'b1, default: 1'b0};
    localparam gcu_op_t OP_SET_PTR   = '{set_ptr: 1'b1, default: 1'b0};
    localparam gcu_op_t OP_WRITE_RAM = '{write_ram: 1'b1, default: 1'b0};
    localparam gcu_op_t OP_READ_H    = '{read_h: 1'b1, default: 1'b0};
    localparam gcu_op_t OP_READ_L    = '{read_l: 1'b1, default: 1'b0};

    logic               CLK96;
    logic               RESET96;
    gcu_op_t            op;
    word_t              din;
    logic               flip_x_in;
    logic               flip_y_in;
    logic [8:0]         h;
    logic [8:0]         v;
    logic [8:0]         hs_start;
    logic [8:0]         hs_end;
    logic [8:0]         vs_start;
    logic [8:0]         vs_end;
    word_t              dout;
    logic               ack;
    logic               vint;
    logic               hsync;
    logic               vsync;
    logic               fblank;
    layer_scroll_t      scroll_regs [NUM_LAYERS];
    logic [BANK_AW-1:0] rd_addr [NUM_BANKS];
    word_t              rd_data [NUM_BANKS];

    // reference model
    word_t              model_ram [2**VRAM_AW];
    layer_scroll_t      model_scroll [NUM_LAYERS];
    logic [7:0]         model_sel;
    logic [VRAM_AW-1:0] model_ptr;
    logic [VRAM_AW-1:0] run_base [$];
    logic [31:0]        lcg_state;

    gcu_top #(.BANK_AW(BANK_AW), .NUM_BANKS(NUM_BANKS)) u_dut (.*);

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped at time %0t", $time);
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    `include "tb_gcu_checks.svh"

    // idle op first, so a repeated op is still seen as a change
    task automatic issue_op(input gcu_op_t o, input word_t d);
        @(posedge CLK96);
        op <= '0;
        @(posedge CLK96);
        op  <= o;
        din <= d;
        @(posedge CLK96);
        wait_ack();
    endtask

    task automatic write_ram(input word_t d);
        issue_op(OP_WRITE_RAM, d);
        model_ram[model_ptr] = d;
        model_ptr = model_ptr + 1'b1;
    endtask

    // read low returns the word after the pointer
    task automatic read_check(input logic low);
        logic [VRAM_AW-1:0] a;
        a = model_ptr + VRAM_AW'(low);
        issue_op(low ? OP_READ_L : OP_READ_H, 16'h0000);
        check_word(dout, model_ram[a], $sformatf("cpu read (low=%b) at %h", low, model_ptr));
    endtask

    task automatic check_render(input logic [VRAM_AW-1:0] a);
        int b;
        b = a[VRAM_AW-1:BANK_AW];
        @(posedge CLK96);
        rd_addr[b] <= a[BANK_AW-1:0];
        @(posedge CLK96);
        @(negedge CLK96);
        check_word(rd_data[b], model_ram[a], $sformatf("render read at %h", a));
    endtask

    task automatic write_reg(input word_t d, input logic fx, input logic fy);
        logic [1:0] l;
        logic       f_in;
        logic       f_old;
        logic       f_new;
        @(posedge CLK96);
        flip_x_in <= fx;
        flip_y_in <= fy;
        issue_op(OP_WRITE_REG, d);
        // only 0x00-0x07 and 0x80-0x87 hold scroll values
        if (model_sel <= 8'h07 || (model_sel >= 8'h80 && model_sel <= 8'h87)) begin
            l     = model_sel[2:1];
            f_in  = model_sel[0] ? fy : fx;
            f_old = model_sel[0] ? model_scroll[l].flip_y : model_scroll[l].flip_x;
            f_new = model_sel[7] ? (f_old | f_in) : (f_old & ~f_in);
            if (model_sel[0]) begin
                model_scroll[l].scroll_y = d;
                model_scroll[l].flip_y   = f_new;
            end else begin
                model_scroll[l].scroll_x = d;
                model_scroll[l].flip_x   = f_new;
            end
        end
        for (int i = 0; i < NUM_LAYERS; i++) begin
            check_scroll(scroll_regs[i], model_scroll[i], $sformatf("layer %0d", i));
        end
    endtask

    initial begin
        CLK96 = 1'b0;
        forever #10 CLK96 = ~CLK96;
    end

    initial begin
        logic [31:0]        r;
        logic [VRAM_AW-1:0] a;
        logic [VRAM_AW-1:0] p;
        logic [7:0]         irq_regs [3];
        logic               exp_h;
        logic               exp_v;
        lcg_state = 32'hd09e_abb9;
        r         = next_rand();
        RESET96   = 1'b1;
        op        = '0;
        din       = '0;
        flip_x_in = r[24];
        flip_y_in = r[27];
        h         = '0;
        v         = '0;
        hs_start  = '0;
        hs_end    = '0;
        vs_start  = '0;
        vs_end    = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            rd_addr[i] = '0;
        end
        model_sel = 8'hFF;
        model_ptr = '0;
        irq_regs  = '{REG_IRQ_A, REG_IRQ_B, REG_IRQ_C};
        for (int i = 0; i < NUM_LAYERS; i++) begin
            model_scroll[i] = '{flip_x: ~r[24], flip_y: ~r[27], scroll_x: '0, scroll_y: '0};
        end
        repeat (16) @(posedge CLK96);
        RESET96 <= 1'b0;
        @(negedge CLK96);
        check_bit(ack, 1'b1, "ack after reset");
        check_bit(vint, 1'b1, "vint after reset");
        for (int i = 0; i < NUM_LAYERS; i++) begin
            check_scroll(scroll_regs[i], model_scroll[i], $sformatf("layer %0d after reset", i));
        end

        // random selects cover the ignored 0x08-0x0F as well
        repeat (32) begin
            r = next_rand();
            issue_op(OP_SELECT, r[23:8]);
            model_sel = r[15:8] & REG_SEL_MASK;
            r = next_rand();
            write_reg(r[31:16], r[24], r[27]);
        end

        // five runs of writes where the first crosses from bank 0 into bank 1
        for (int k = 0; k < 5; k++) begin
            r = next_rand();
            p = (k == 0) ? 13'h07FD : r[28:16];
            run_base.push_back(p);
            issue_op(OP_SET_PTR, {r[31:29], p});
            model_ptr = p;
            repeat (RUN_LEN) begin
                r = next_rand();
                write_ram(r[31:16]);
            end
            a = p;
            repeat (RUN_LEN) begin
                check_render(a);
                a = a + 1'b1;
            end
        end

        // a read keeps the pointer, so the next write lands on it
        repeat (12) begin
            r = next_rand();
            p = run_base[r[31:24] % run_base.size()] + VRAM_AW'(r[23:16] % (RUN_LEN - 1));
            issue_op(OP_SET_PTR, {3'b000, p});
            model_ptr = p;
            read_check(r[15]);
            r = next_rand();
            write_ram(r[31:16]);
            check_render(p);
        end

        for (int i = 0; i < 3; i++) begin
            @(posedge CLK96);
            v <= VINT_CLEAR_LINE;
            wait_vint(1'b0);
            @(posedge CLK96);
            v <= 9'h010;
            r = next_rand();
            issue_op(OP_SELECT, {r[31:24], irq_regs[i] | {1'b0, r[22:20], 4'h0}});
            wait_vint(1'b1);
        end
        @(posedge CLK96);
        v <= VINT_CLEAR_LINE;
        wait_vint(1'b0);
        @(posedge CLK96);
        v <= 9'h010;
        issue_op(OP_SELECT, 16'h0005);
        repeat (3) @(negedge CLK96);
        check_bit(vint, 1'b0, "vint after select of 0x05");

        repeat (40) begin
            r = next_rand();
            @(posedge CLK96);
            h        <= r[31:23];
            hs_start <= r[22:14];
            hs_end   <= r[13:5];
            r = next_rand();
            v        <= r[31:23];
            vs_start <= r[22:14];
            vs_end   <= r[13:5];
            @(negedge CLK96);
            exp_h = !(h > hs_start && h < hs_end);
            exp_v = !(v >= vs_start && v <= vs_end);
            check_bit(hsync, exp_h, "hsync");
            check_bit(vsync, exp_v, "vsync");
            check_bit(fblank, exp_h & exp_v, "fblank");
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/gcu_top.sv
// single clock domain; the CPU side holds each op until ack is high, with no other handshake
`timescale 1ns/1ps
`default_nettype none

module gcu_top #(
    parameter int BANK_AW   = gcu_pkg::BANK_AW,
    parameter int NUM_BANKS = gcu_pkg::NUM_BANKS
) (
    input  wire logic                 CLK96,
    input  wire logic                 RESET96,
    input  wire gcu_pkg::gcu_op_t     op,
    input  wire gcu_pkg::word_t       din,
    input  wire logic                 flip_x_in,
    input  wire logic                 flip_y_in,
    input  wire logic [8:0]           h,
    input  wire logic [8:0]           v,
    input  wire logic [8:0]           hs_start,
    input  wire logic [8:0]           hs_end,
    input  wire logic [8:0]           vs_start,
    input  wire logic [8:0]           vs_end,
    output gcu_pkg::word_t            dout,
    output logic                      ack,
    output logic                      vint,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      fblank,
    output gcu_pkg::layer_scroll_t    scroll_regs [gcu_pkg::NUM_LAYERS],
    input  wire logic [BANK_AW-1:0]   rd_addr [NUM_BANKS],
    output gcu_pkg::word_t            rd_data [NUM_BANKS]
);
    import gcu_pkg::*;

    vram_wr_t           vram_wr;
    logic [VRAM_AW-1:0] ram_ptr;
    logic               ctrl_ack;
    logic               irq_sel;
    logic [BANK_AW-1:0] cpu_addr;
    word_t              cpu_data [NUM_BANKS];

    gcu_bus_ctrl u_bus_ctrl (
        .CLK96       (CLK96),
        .RESET96     (RESET96),
        .op          (op),
        .din         (din),
        .flip_x_in   (flip_x_in),
        .flip_y_in   (flip_y_in),
        .scroll_regs (scroll_regs),
        .vram_wr     (vram_wr),
        .ram_ptr     (ram_ptr),
        .ctrl_ack    (ctrl_ack),
        .irq_sel     (irq_sel)
    );

    // bank 3 holds the sprite table, banks 0 to 2 the scroll layers
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        vram_bank #(
            .BANK_AW    (BANK_AW),
            .BANK_INDEX (i)
        ) u_bank (
            .CLK96    (CLK96),
            .vram_wr  (vram_wr),
            .rd_addr  (rd_addr[i]),
            .cpu_addr (cpu_addr),
            .rd_data  (rd_data[i]),
            .cpu_data (cpu_data[i])
        );
    end

    cpu_read_seq #(
        .BANK_AW   (BANK_AW),
        .NUM_BANKS (NUM_BANKS)
    ) u_read_seq (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .op       (op),
        .ram_ptr  (ram_ptr),
        .ctrl_ack (ctrl_ack),
        .cpu_data (cpu_data),
        .cpu_addr (cpu_addr),
        .dout     (dout),
        .ack      (ack)
    );

    frame_sync_irq u_sync_irq (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .irq_sel  (irq_sel),
        .h        (h),
        .v        (v),
        .hs_start (hs_start),
        .hs_end   (hs_end),
        .vs_start (vs_start),
        .vs_end   (vs_end),
        .vint     (vint),
        .hsync    (hsync),
        .vsync    (vsync),
        .fblank   (fblank)
    );

endmodule

`default_nettype wire

// File: logic/frame_sync_irq.sv
// sync and blank are combinational from the counters; vint clears only on line 0xE6
`timescale 1ns/1ps
`default_nettype none

module frame_sync_irq (
    input  wire logic       CLK96,
    input  wire logic       RESET96,
    input  wire logic       irq_sel,
    input  wire logic [8:0] h,
    input  wire logic [8:0] v,
    input  wire logic [8:0] hs_start,
    input  wire logic [8:0] hs_end,
    input  wire logic [8:0] vs_start,
    input  wire logic [8:0] vs_end,
    output logic            vint,
    output logic            hsync,
    output logic            vsync,
    output logic            fblank
);
    import gcu_pkg::*;

    // active low; horizontal window is open, vertical is closed
    assign hsync  = !((h > hs_start) && (h < hs_end));
    assign vsync  = !((v >= vs_start) && (v <= vs_end));
    assign fblank = hsync && vsync;

    // select of an irq register wins over the clear line
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            vint <= 1'b1;
        end else if (irq_sel) begin
            vint <= 1'b1;
        end else if (v == VINT_CLEAR_LINE) begin
            vint <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/cpu_read_seq.sv
// three-edge CPU read of video RAM; the pointer must stay put while a read is in flight
`timescale 1ns/1ps
`default_nettype none

module cpu_read_seq #(
    parameter int BANK_AW   = gcu_pkg::BANK_AW,
    parameter int NUM_BANKS = gcu_pkg::NUM_BANKS
) (
    input  wire logic                        CLK96,
    input  wire logic                        RESET96,
    input  wire gcu_pkg::gcu_op_t            op,
    input  wire logic [gcu_pkg::VRAM_AW-1:0] ram_ptr,
    input  wire logic                        ctrl_ack,
    input  wire gcu_pkg::word_t              cpu_data [NUM_BANKS],
    output logic [BANK_AW-1:0]               cpu_addr,
    output gcu_pkg::word_t                   dout,
    output logic                             ack
);
    import gcu_pkg::*;

    localparam int BW = VRAM_AW - BANK_AW;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_LOAD
    } rd_state_t;

    rd_state_t          state;
    gcu_op_t            last_op;
    logic [BW-1:0]      bank_sel;
    logic [VRAM_AW-1:0] rd_ptr;
    logic               read_start;
    logic               seq_ack;

    // read low fetches the word after the pointer
    assign rd_ptr     = ram_ptr + VRAM_AW'(op.read_l);
    assign read_start = (op != last_op) && (op.read_h || op.read_l);
    assign ack        = seq_ack & ctrl_ack;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state    <= ST_IDLE;
            last_op  <= '0;
            bank_sel <= '0;
            seq_ack  <= 1'b1;
        end else begin
            last_op <= op;
            if (read_start) begin
                bank_sel <= rd_ptr[VRAM_AW-1:BANK_AW];
                seq_ack  <= 1'b0;
                state    <= ST_WAIT;
            end else if (state == ST_WAIT) begin
                // bank output registers this edge
                state <= ST_LOAD;
            end else if (state == ST_LOAD) begin
                seq_ack <= 1'b1;
                state   <= ST_IDLE;
            end
        end
    end

    always_ff @(posedge CLK96) begin
        if (read_start) begin
            cpu_addr <= rd_ptr[BANK_AW-1:0];
        end
        if (state == ST_LOAD) begin
            dout <= cpu_data[bank_sel];
        end
    end

endmodule

`default_nettype wire

// File: logic/vram_bank.sv
// one video RAM bank with registered reads; contents are undefined until written
`timescale 1ns/1ps
`default_nettype none

module vram_bank #(
    parameter int BANK_AW    = gcu_pkg::BANK_AW,
    parameter int BANK_INDEX = 0
) (
    input  wire logic                 CLK96,
    input  wire gcu_pkg::vram_wr_t    vram_wr,
    input  wire logic [BANK_AW-1:0]   rd_addr,
    input  wire logic [BANK_AW-1:0]   cpu_addr,
    output gcu_pkg::word_t            rd_data,
    output gcu_pkg::word_t            cpu_data
);
    import gcu_pkg::*;

    localparam int BW = VRAM_AW - BANK_AW;
    localparam logic [BW-1:0] BANK_ID = BW'(BANK_INDEX);

    word_t mem [2**BANK_AW];
    logic  bank_we;

    // upper address bits pick the bank
    assign bank_we = vram_wr.we && (vram_wr.addr[VRAM_AW-1:BANK_AW] == BANK_ID);

    always_ff @(posedge CLK96) begin
        if (bank_we) begin
            mem[vram_wr.addr[BANK_AW-1:0]] <= vram_wr.data;
        end
        // renderer port
        rd_data  <= mem[rd_addr];
        // CPU read-back port
        cpu_data <= mem[cpu_addr];
    end

endmodule

`default_nettype wire

// File: logic/gcu_bus_ctrl.sv
// acts once per change of the op vector; a write-RAM op must be held until ack returns high
`timescale 1ns/1ps
`default_nettype none

module gcu_bus_ctrl (
    input  wire logic                    CLK96,
    input  wire logic                    RESET96,
    input  wire gcu_pkg::gcu_op_t        op,
    input  wire gcu_pkg::word_t          din,
    input  wire logic                    flip_x_in,
    input  wire logic                    flip_y_in,
    output gcu_pkg::layer_scroll_t       scroll_regs [gcu_pkg::NUM_LAYERS],
    output gcu_pkg::vram_wr_t            vram_wr,
    output logic [gcu_pkg::VRAM_AW-1:0]  ram_ptr,
    output logic                         ctrl_ack,
    output logic                         irq_sel
);
    import gcu_pkg::*;

    gcu_op_t    last_op;
    logic [7:0] sel_reg;
    logic [7:0] sel_next;
    logic       op_new;
    logic       is_scroll_reg;
    logic [1:0] layer;
    logic       flip_old;
    logic       flip_in;
    logic       flip_new;

    assign op_new   = (op != last_op);
    assign sel_next = din[7:0] & REG_SEL_MASK;

    // registers 0x00-0x07 and 0x80-0x87 only; 0x08-0x0F fall through
    assign is_scroll_reg = (sel_reg[6:3] == 4'b0000);
    assign layer         = sel_reg[2:1];

    // bit 0 picks Y over X, bit 7 picks OR over AND-NOT
    assign flip_old = sel_reg[0] ? scroll_regs[layer].flip_y : scroll_regs[layer].flip_x;
    assign flip_in  = sel_reg[0] ? flip_y_in : flip_x_in;
    assign flip_new = sel_reg[7] ? (flip_old | flip_in) : (flip_old & ~flip_in);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            for (int i = 0; i < NUM_LAYERS; i++) begin
                scroll_regs[i].flip_x   <= ~flip_x_in;
                scroll_regs[i].flip_y   <= ~flip_y_in;
                scroll_regs[i].scroll_x <= '0;
                scroll_regs[i].scroll_y <= '0;
            end
            last_op  <= '0;
            sel_reg  <= 8'hFF;
            ram_ptr  <= '0;
            vram_wr  <= '0;
            ctrl_ack <= 1'b1;
            irq_sel  <= 1'b0;
        end else begin
            last_op <= op;
            irq_sel <= 1'b0;

            if (vram_wr.we) begin
                // second edge of a RAM write
                vram_wr.we <= 1'b0;
                ram_ptr    <= ram_ptr + 1'b1;
                ctrl_ack   <= 1'b1;
            end else if (op_new) begin
                if (op.select_reg) begin
                    sel_reg <= sel_next;
                    irq_sel <= (sel_next == REG_IRQ_A) || (sel_next == REG_IRQ_B) ||
                               (sel_next == REG_IRQ_C);
                end else if (op.write_reg) begin
                    if (is_scroll_reg) begin
                        if (sel_reg[0]) begin
                            scroll_regs[layer].scroll_y <= din;
                            scroll_regs[layer].flip_y   <= flip_new;
                        end else begin
                            scroll_regs[layer].scroll_x <= din;
                            scroll_regs[layer].flip_x   <= flip_new;
                        end
                    end
                end else if (op.set_ptr) begin
                    ram_ptr <= din[VRAM_AW-1:0];
                end else if (op.write_ram) begin
                    vram_wr.we   <= 1'b1;
                    vram_wr.addr <= ram_ptr;
                    vram_wr.data <= din;
                    ctrl_ack     <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/gcu_pkg.sv
// shared GCU definitions; address layout assumes the 8K-word map split into four 2K-word banks
`default_nettype none

package gcu_pkg;

    // video RAM geometry
    localparam int VRAM_AW    = 13;
    localparam int BANK_AW    = 11;
    localparam int NUM_BANKS  = 4;
    localparam int NUM_LAYERS = 4;

    typedef logic [15:0] word_t;

    // level-coded bus operations that the CPU side holds
    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic set_ptr;
        logic write_ram;
        logic read_h;
        logic read_l;
    } gcu_op_t;

    // one of the background, foreground, text and sprite layers
    typedef struct packed {
        logic  flip_x;
        logic  flip_y;
        word_t scroll_x;
        word_t scroll_y;
    } layer_scroll_t;

    // write request broadcast to every bank
    typedef struct packed {
        logic               we;
        logic [VRAM_AW-1:0] addr;
        word_t              data;
    } vram_wr_t;

    localparam logic [7:0] REG_SEL_MASK    = 8'h8F;
    localparam logic [7:0] REG_IRQ_A       = 8'h0E;
    localparam logic [7:0] REG_IRQ_B       = 8'h0F;
    localparam logic [7:0] REG_IRQ_C       = 8'h8F;
    localparam logic [8:0] VINT_CLEAR_LINE = 9'h0E6;

endpackage

`default_nettype wire
